// File: Makefile
# run from the project root so that the rom finds bench/program.hex
TOP = tb_top_core

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f design/*.sv bench/*.sv
	verilator --binary --assert --top-module $(TOP) -f src.f

# the log decides, a missing pass line counts as failure too
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	! grep -q "Testbench failed" sim.log
	grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir sim.log

// File: bench/program.hex
// one 32-bit instruction per line, @ sets the word index (byte address / 4)
// words 0x00 on configure and loop, word 0x80 + 4*i is handler i at byte 0x200 + 16*i
@000
// csrrwi to the configs: source 0 prio 1, source 1 prio 2, source 2 prio 3, all enabled
7D01D073
7D12D073
7D23D073
// source 3 prio 2, enable bit left clear
7D325073
// main loop reads the level into x2, counts in x1
7E002173
00108093
FF9FF06F
// handler i writes i + 1 to pins_out, then mret
@080
7C00D073
30200073
@084
7C015073
30200073
@088
7C01D073
30200073
@08C
7C025073
30200073

// File: bench/tb_top_core.sv
// expects program.hex to enable sources 0..2 at prio 1..3 and leave source 3 off; run from root
`timescale 1ns/1ns
`default_nettype none

module tb_top_core import core_pkg::*; ();

  logic clk;
  logic rst;
  irq_vec_t irq_req;
  irq_vec_t irq_ack;
  logic [3:0] pins_out;

  integer seed;
  int unsigned cycle_cnt;
  int unsigned max_cycles;
  // device state: 0 idle wait, 1 req high, 2 waiting for ack low
  int phase [NUM_IRQ];
  int wait_cnt [NUM_IRQ];
  int done_cnt [NUM_IRQ];
  // cycles of req high without ack, per source
  int req_age [NUM_IRQ];
  irq_vec_t ack_seen;
  irq_vec_t acked_since;
  logic [3:0] pins_prev;

  top_core UUT (.clk, .rst, .irq_req, .irq_ack, .pins_out);

  always #4 clk = ~clk;

  function automatic int rand_between(int lo, int hi);
    int r;
    r = $random(seed);
    return lo + ((r & 32'h7fff_ffff) % (hi - lo + 1));
  endfunction

  // configuration the program writes
  function automatic logic src_enabled(int i);
    return i != 3;
  endfunction

  function automatic int src_prio(int i);
    case (i)
      0: return 1;
      1: return 2;
      2: return 3;
      default: return 2;
    endcase
  endfunction

  function automatic logic handshakes_done();
    for (int i = 0; i < NUM_IRQ; i++) begin
      if (src_enabled(i) && done_cnt[i] < 15) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_eq(string name, word_t expected, word_t got);
    if (expected !== got) stop_with_failure($sformatf("error %s %h %h", name, expected, got));
  endtask

  initial begin
    seed = 32'ha343_956e;
    clk = 1'b0;
    rst = 1'b1;
    irq_req = '0;
    cycle_cnt = 0;
    // sixty requests at up to sixty cycles each
    max_cycles = 60 * 60;
    ack_seen = '0;
    acked_since = '0;
    pins_prev = '0;
    for (int i = 0; i < NUM_IRQ; i++) begin
      phase[i] = 0;
      wait_cnt[i] = rand_between(5, 40);
      done_cnt[i] = 0;
      req_age[i] = 0;
    end
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    // nothing configured yet
    @(negedge clk);
    check_eq("irq_ack", 32'd0, word_t'(irq_ack));
    check_eq("pins_out", 32'd0, word_t'(pins_out));
    while (!handshakes_done()) @(posedge clk);
    $display("handshakes %0d %0d %0d in %0d cycles", done_cnt[0], done_cnt[1], done_cnt[2],
             cycle_cnt);
    $display("Testbench passed");
    $finish;
  end

  // request devices, one process so the random sequence is fixed
  always @(posedge clk) begin
    if (!rst) begin
      // drive 1 ns after the edge
      #1;
      for (int i = 0; i < NUM_IRQ; i++) begin
        case (phase[i])
          0: begin
            if (wait_cnt[i] > 0) begin
              wait_cnt[i]--;
            end else begin
              irq_req[i] = 1'b1;
              phase[i] = 1;
              // disabled source gives up after a while
              wait_cnt[i] = rand_between(10, 30);
            end
          end
          1: begin
            if (src_enabled(i) ? ack_seen[i] : wait_cnt[i] == 0) begin
              irq_req[i] = 1'b0;
              phase[i] = 2;
            end else if (!src_enabled(i)) begin
              wait_cnt[i]--;
            end
          end
          default: begin
            if (!ack_seen[i]) begin
              if (src_enabled(i)) done_cnt[i]++;
              wait_cnt[i] = rand_between(5, 40);
              phase[i] = 0;
            end
          end
        endcase
      end
    end
  end

  // monitor at the falling edge, all outputs settled
  always @(negedge clk) begin
    logic matched;
    if (!rst) begin
      cycle_cnt++;
      if (cycle_cnt > max_cycles) begin
        stop_with_failure($sformatf("timeout, handshakes %0d %0d %0d after %0d cycles",
                                    done_cnt[0], done_cnt[1], done_cnt[2], cycle_cnt));
      end
      // pins first, a rise on this edge cannot explain this change
      if (pins_out != pins_prev) begin
        matched = 1'b0;
        for (int j = 0; j < NUM_IRQ; j++) begin
          if (acked_since[j] && pins_out == 4'(j + 1)) matched = 1'b1;
        end
        if (!matched) begin
          stop_with_failure($sformatf("pins_out changed to %h with no matching handler", pins_out));
        end
        acked_since = '0;
      end
      for (int i = 0; i < NUM_IRQ; i++) begin
        if (irq_ack[i] && !ack_seen[i]) begin
          check_eq($sformatf("irq_ack[%0d]", i), word_t'(src_enabled(i)), word_t'(irq_ack[i]));
          check_eq($sformatf("irq_req[%0d]", i), 32'd1, word_t'(irq_req[i]));
          // no higher source may have been left waiting
          for (int j = 0; j < NUM_IRQ; j++) begin
            if (src_enabled(j) && src_prio(j) > src_prio(i) && req_age[j] >= 4) begin
              stop_with_failure($sformatf("source %0d acked while source %0d waited %0d cycles",
                                          i, j, req_age[j]));
            end
          end
          acked_since[i] = 1'b1;
        end
        if (!irq_ack[i] && ack_seen[i]) begin
          check_eq($sformatf("irq_req[%0d]", i), 32'd0, word_t'(irq_req[i]));
        end
      end
      // ages only after the checks
      for (int i = 0; i < NUM_IRQ; i++) begin
        req_age[i] = (irq_req[i] && !irq_ack[i]) ? req_age[i] + 1 : 0;
      end
    end
    ack_seen = irq_ack;
    pins_prev = pins_out;
  end

endmodule

`default_nettype wire

// File: bench/tb_top_core_asserts.sv
// req/ack checks at the top pins; ack 3 must stay low because the program never enables source 3
`timescale 1ns/1ns
`default_nettype none

module irq_protocol_checks import core_pkg::*; (
  input logic     clk,
  input logic     rst,
  input irq_vec_t irq_req,
  input irq_vec_t irq_ack,
  input prio_t    level
);

  // ack only rises on a live request
  ack_rise_with_req: assert property (@(posedge clk) disable iff (rst)
    ((irq_ack & ~$past(irq_ack)) & ~irq_req) == '0)
    else $error("ack rose while its request was low");

  // ack only falls once the request is gone
  ack_fall_after_req: assert property (@(posedge clk) disable iff (rst)
    ((~irq_ack & $past(irq_ack)) & irq_req) == '0)
    else $error("ack fell while its request was still high");

  disabled_source_silent: assert property (@(posedge clk) disable iff (rst) !irq_ack[3])
    else $error("disabled source 3 was acknowledged");

  // a new ack marks a take, which moves the level strictly up
  ack_rise_raises_level: assert property (@(posedge clk) disable iff (rst)
    (irq_ack & ~$past(irq_ack)) != '0 |-> level > $past(level))
    else $error("ack rose without the level going up");

endmodule

bind top_core irq_protocol_checks u_checks (
  .clk, .rst, .irq_req, .irq_ack, .level(u_arbiter.level_q)
);

`default_nettype wire

// File: design/clic_arbiter.sv
// nested priority arbiter; no take in an mret cycle, mret at thread level keeps the sequential pc
`timescale 1ns/1ns
`default_nettype none

module clic_arbiter import core_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  csr_req_t                 csr_req,
  input  irq_vec_t                 pending,
  input  prio_t [NUM_IRQ-1:0]      prio_bus,
  input  word_t [NUM_IRQ-1:0]      cfg_bus,
  input  word_t                    pins_rdata,
  input  logic                     mret,
  input  imem_addr_t               pc_normal,
  output irq_vec_t                 take,
  output imem_addr_t               pc_next,
  output word_t                    csr_rdata
);

  prio_t level_q;
  // return pcs and the level each interrupt preempted
  imem_addr_t ret_pc [STACK_DEPTH];
  prio_t prev_level [STACK_DEPTH];
  logic [1:0] sp_q;
  logic [1:0] top;
  logic win_valid;
  logic take_valid;
  irq_idx_t win_idx;
  prio_t win_prio;
  logic pop;

  // strictly above current level, lowest index wins a tie
  always_comb begin
    win_valid = 1'b0;
    win_idx = '0;
    win_prio = level_q;
    for (int i = 0; i < NUM_IRQ; i++) begin
      if (pending[i] && prio_bus[i] > win_prio) begin
        win_valid = 1'b1;
        win_idx = irq_idx_t'(i);
        win_prio = prio_bus[i];
      end
    end
  end

  assign take_valid = win_valid && !mret;
  assign take = take_valid ? irq_vec_t'(1) << win_idx : '0;
  assign top = sp_q - 2'd1;
  assign pop = mret && sp_q != 2'd0;

  // redirect to vector, or back to the preempted pc
  always_comb begin
    if (take_valid) pc_next = IRQ_VECTOR_BASE + (imem_addr_t'(win_idx) << 4);
    else if (pop) pc_next = ret_pc[top];
    else pc_next = pc_normal;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      level_q <= '0;
      sp_q <= '0;
    end else if (take_valid) begin
      level_q <= win_prio;
      sp_q <= sp_q + 2'd1;
    end else if (pop) begin
      level_q <= prev_level[top];
      sp_q <= top;
    end
  end

  // the instruction in the take cycle completes, so pc_normal is pushed
  always_ff @(posedge clk) begin
    if (take_valid) begin
      ret_pc[sp_q] <= pc_normal;
      prev_level[sp_q] <= level_q;
    end
  end

  // readback of the old value, zero for unmapped addresses
  always_comb begin
    csr_rdata = '0;
    if (csr_req.op != csr_none) begin
      for (int i = 0; i < NUM_IRQ; i++) begin
        if (csr_req.addr == CSR_IRQ_CFG_BASE + csr_addr_t'(i)) csr_rdata = cfg_bus[i];
      end
      if (csr_req.addr == CSR_IRQ_LEVEL) csr_rdata = word_t'(level_q);
      if (csr_req.addr == CSR_PINS_OUT) csr_rdata = pins_rdata;
    end
  end

endmodule

`default_nettype wire

// File: design/clic_entry.sv
// one interrupt source; config bit 0 enable, bits 2:1 priority, upper config bits read as zero
`timescale 1ns/1ns
`default_nettype none

module clic_entry import core_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  csr_req_t  csr_req,
  input  csr_addr_t cfg_addr,
  input  logic      req_sync,
  input  logic      take,
  output logic      pending,
  output prio_t     prio,
  output word_t     cfg,
  output logic      ack
);

  logic [2:0] cfg_q;
  word_t cfg_next;

  assign cfg_next = csr_apply(csr_req.op, cfg, csr_req.wdata);

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_q <= '0;
    end else if (csr_req.addr == cfg_addr) begin
      cfg_q <= cfg_next[2:0];
    end
  end

  // four-phase handshake with the device
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
      ack <= 1'b0;
    end else if (take) begin
      pending <= 1'b0;
      ack <= 1'b1;
    end else if (ack) begin
      // hold ack until req is seen low
      if (!req_sync) ack <= 1'b0;
    end else begin
      // withdrawn req or disable drops pending
      pending <= req_sync && cfg_q[0];
    end
  end

  assign prio = cfg_q[2:1];
  assign cfg = word_t'(cfg_q);

endmodule

`default_nettype wire

// File: design/core_pkg.sv
// shared types for the rv32 subset core; rom depth, irq count and csr map are fixed, not overridable
`default_nettype none

package core_pkg;

  // widths with a meaning of their own
  typedef logic [31:0] word_t;
  typedef logic [9:0] imem_addr_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [11:0] csr_addr_t;
  // level 0 is thread level, priority 0 never interrupts
  typedef logic [1:0] prio_t;

  localparam int NUM_IRQ = 4;
  typedef logic [NUM_IRQ-1:0] irq_vec_t;
  typedef logic [$clog2(NUM_IRQ)-1:0] irq_idx_t;

  // 256 words, hex path relative to the run directory
  localparam int ROM_WORDS = 256;
  localparam string ROM_FILE = "bench/program.hex";
  // one return slot per level above thread
  localparam int STACK_DEPTH = 3;

  // handler i at base + 16*i
  localparam imem_addr_t IRQ_VECTOR_BASE = 10'h200;
  localparam csr_addr_t CSR_PINS_OUT = 12'h7C0;
  localparam csr_addr_t CSR_IRQ_CFG_BASE = 12'h7D0;
  localparam csr_addr_t CSR_IRQ_LEVEL = 12'h7E0;

  // major opcodes of the subset
  localparam logic [6:0] OPC_OP = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
  localparam word_t MRET_INSTR = 32'h3020_0073;

  // zero members double as the no-op decode
  typedef enum logic [1:0] {alu_add, alu_sub, alu_pass_b} alu_op_t;
  typedef enum logic [1:0] {br_none, br_eq, br_ne, br_always} branch_op_t;
  typedef enum logic [1:0] {wb_alu, wb_csr, wb_pc_plus_4} wb_sel_t;
  typedef enum logic [1:0] {csr_none, csr_write, csr_set, csr_clear} csr_op_t;

  typedef struct packed {
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    logic       rd_we;
    word_t      imm;
    logic       use_imm;
    alu_op_t    alu_op;
    branch_op_t branch_op;
    wb_sel_t    wb_sel;
    csr_op_t    csr_op;
    csr_addr_t  csr_addr;
    logic       csr_zimm;
    logic       mret;
  } ctrl_t;

  // broadcast to every csr holder each cycle
  typedef struct packed {
    csr_op_t   op;
    csr_addr_t addr;
    word_t     wdata;
  } csr_req_t;

  // write, set and clear as used by every csr holder
  function automatic word_t csr_apply(csr_op_t op, word_t old, word_t wdata);
    case (op)
      csr_write: return wdata;
      csr_set:   return old | wdata;
      csr_clear: return old & ~wdata;
      default:   return old;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: design/csr_pins.sv
// pins_out csr; only the low four bits exist, upper bits read as zero
`timescale 1ns/1ns
`default_nettype none

module csr_pins import core_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  csr_req_t   csr_req,
  output logic [3:0] pins_out,
  output word_t      pins_rdata
);

  word_t pins_next;

  assign pins_rdata = word_t'(pins_out);
  assign pins_next = csr_apply(csr_req.op, pins_rdata, csr_req.wdata);

  always_ff @(posedge clk) begin
    if (rst) pins_out <= '0;
    else if (csr_req.addr == CSR_PINS_OUT) pins_out <= pins_next[3:0];
  end

endmodule

`default_nettype wire

// File: design/decoder.sv
// decodes add/sub/addi/beq/bne/jal/csrrw/csrrs/csrrc/csrrwi/mret only; all else is a no-op
`timescale 1ns/1ns
`default_nettype none

module decoder import core_pkg::*; (
  input  word_t instr,
  output ctrl_t ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t imm_i;
  word_t imm_b;
  word_t imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // sign extended, b and j with implicit zero lsb
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    // no-op unless a case below says otherwise
    ctrl = '0;
    ctrl.rs1 = instr[19:15];
    ctrl.rs2 = instr[24:20];
    ctrl.rd = instr[11:7];
    ctrl.csr_addr = instr[31:20];
    case (opcode)
      OPC_OP: begin
        // add and sub share funct3, funct7 picks
        if (funct3 == 3'b000 && funct7 == 7'h00) begin
          ctrl.rd_we = 1'b1;
        end else if (funct3 == 3'b000 && funct7 == 7'h20) begin
          ctrl.rd_we = 1'b1;
          ctrl.alu_op = alu_sub;
        end
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          ctrl.rd_we = 1'b1;
          ctrl.use_imm = 1'b1;
          ctrl.imm = imm_i;
        end
      end
      OPC_BRANCH: begin
        ctrl.imm = imm_b;
        if (funct3 == 3'b000) ctrl.branch_op = br_eq;
        else if (funct3 == 3'b001) ctrl.branch_op = br_ne;
      end
      OPC_JAL: begin
        // link register gets pc + 4
        ctrl.imm = imm_j;
        ctrl.branch_op = br_always;
        ctrl.rd_we = 1'b1;
        ctrl.wb_sel = wb_pc_plus_4;
      end
      OPC_SYSTEM: begin
        ctrl.mret = (instr == MRET_INSTR);
        case (funct3)
          3'b001: ctrl.csr_op = csr_write;
          3'b010: ctrl.csr_op = csr_set;
          3'b011: ctrl.csr_op = csr_clear;
          3'b101: begin
            // rs1 field is the 5-bit zimm here
            ctrl.csr_op = csr_write;
            ctrl.csr_zimm = 1'b1;
          end
          default: ctrl.csr_op = csr_none;
        endcase
        // old csr value goes back to rd
        if (ctrl.csr_op != csr_none) begin
          ctrl.rd_we = 1'b1;
          ctrl.wb_sel = wb_csr;
        end
      end
      default: ctrl.rd_we = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/exec_unit.sv
// register file, alu and branch compare; branch targets wrap in the 10-bit rom address space
`timescale 1ns/1ns
`default_nettype none

module exec_unit import core_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  ctrl_t      ctrl,
  input  imem_addr_t pc,
  input  word_t      csr_rdata,
  output imem_addr_t pc_normal,
  output word_t      csr_wdata
);

  // x1..x31, x0 is hardwired
  word_t regs [1:31];
  word_t rs1_data;
  word_t rs2_data;
  word_t op_b;
  word_t alu_res;
  word_t wb_data;
  logic branch_taken;
  imem_addr_t pc_plus_4;
  imem_addr_t pc_target;

  assign rs1_data = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
  assign rs2_data = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];

  // second operand is rs2 or the immediate
  assign op_b = ctrl.use_imm ? ctrl.imm : rs2_data;

  always_comb begin
    case (ctrl.alu_op)
      alu_sub:    alu_res = rs1_data - op_b;
      alu_pass_b: alu_res = op_b;
      default:    alu_res = rs1_data + op_b;
    endcase
  end

  always_comb begin
    case (ctrl.branch_op)
      br_eq:     branch_taken = (rs1_data == rs2_data);
      br_ne:     branch_taken = (rs1_data != rs2_data);
      br_always: branch_taken = 1'b1;
      default:   branch_taken = 1'b0;
    endcase
  end

  // pc relative target, low 10 bits are enough
  assign pc_plus_4 = pc + imem_addr_t'(4);
  assign pc_target = pc + ctrl.imm[9:0];
  assign pc_normal = branch_taken ? pc_target : pc_plus_4;

  // zimm is zero extended
  assign csr_wdata = ctrl.csr_zimm ? word_t'(ctrl.rs1) : rs1_data;

  always_comb begin
    case (ctrl.wb_sel)
      wb_csr:       wb_data = csr_rdata;
      wb_pc_plus_4: wb_data = word_t'(pc_plus_4);
      default:      wb_data = alu_res;
    endcase
  end

  // no writeback while reset holds pc at 0
  always_ff @(posedge clk) begin
    if (!rst && ctrl.rd_we && ctrl.rd != '0) begin
      regs[ctrl.rd] <= wb_data;
    end
  end

endmodule

`default_nettype wire

// File: design/irq_capture.sv
// two-flop synchronizer per request line; adds exactly two cycles of latency, no glitch filter
`timescale 1ns/1ns
`default_nettype none

module irq_capture import core_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  irq_vec_t irq_req,
  output irq_vec_t req_sync
);

  // first stage may go metastable
  irq_vec_t meta_q;
  // second stage is what the entries see
  irq_vec_t sync_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= irq_req;
      sync_q <= meta_q;
    end
  end

  assign req_sync = sync_q;

endmodule

`default_nettype wire

// File: design/rom.sv
// combinational 256-word rom, loaded from ROM_FILE at elaboration; simulation and fpga init only
`timescale 1ns/1ns
`default_nettype none

module rom import core_pkg::*; (
  input  imem_addr_t addr,
  output word_t      data
);

  word_t mem [ROM_WORDS];

  // byte address, word aligned
  logic [7:0] word_idx;

  assign word_idx = addr[9:2];

  initial begin
    $readmemh(ROM_FILE, mem);
  end

  assign data = mem[word_idx];

endmodule

`default_nettype wire

// File: design/top_core.sv
// single-cycle core with four-source nested interrupt controller; one instruction per clock
`timescale 1ns/1ns
`default_nettype none

module top_core import core_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  irq_vec_t   irq_req,
  output irq_vec_t   irq_ack,
  output logic [3:0] pins_out
);

  imem_addr_t pc;
  imem_addr_t pc_next;
  imem_addr_t pc_normal;
  word_t instr;
  ctrl_t ctrl;
  word_t csr_rdata;
  word_t csr_wdata;
  word_t pins_rdata;
  csr_req_t csr_req;
  irq_vec_t req_sync;
  irq_vec_t pending;
  irq_vec_t take;
  prio_t [NUM_IRQ-1:0] prio_bus;
  word_t [NUM_IRQ-1:0] cfg_bus;

  // pc register, the arbiter picks the next value
  always_ff @(posedge clk) begin
    if (rst) pc <= '0;
    else pc <= pc_next;
  end

  rom u_rom (.addr(pc), .data(instr));

  decoder u_decoder (.instr, .ctrl);

  exec_unit u_exec (.clk, .rst, .ctrl, .pc, .csr_rdata, .pc_normal, .csr_wdata);

  // csr access goes to every holder
  assign csr_req.op = ctrl.csr_op;
  assign csr_req.addr = ctrl.csr_addr;
  assign csr_req.wdata = csr_wdata;

  irq_capture u_capture (.clk, .rst, .irq_req, .req_sync);

  // one entry per source, config address from the index
  for (genvar i = 0; i < NUM_IRQ; i++) begin : g_entry
    clic_entry u_entry (
      .clk, .rst, .csr_req,
      .cfg_addr(CSR_IRQ_CFG_BASE + csr_addr_t'(i)),
      .req_sync(req_sync[i]), .take(take[i]),
      .pending(pending[i]), .prio(prio_bus[i]), .cfg(cfg_bus[i]), .ack(irq_ack[i])
    );
  end

  clic_arbiter u_arbiter (
    .clk, .rst, .csr_req, .pending, .prio_bus, .cfg_bus, .pins_rdata,
    .mret(ctrl.mret), .pc_normal,
    .take, .pc_next, .csr_rdata
  );

  csr_pins u_pins (.clk, .rst, .csr_req, .pins_out, .pins_rdata);

endmodule

`default_nettype wire

// File: src.f
design/core_pkg.sv
design/decoder.sv
design/exec_unit.sv
design/irq_capture.sv
design/clic_entry.sv
design/clic_arbiter.sv
design/csr_pins.sv
design/rom.sv
design/top_core.sv
bench/tb_top_core_asserts.sv
bench/tb_top_core.sv
